// ==== dv/tile_mem_cases.txt ====
# kind op addr data expected_data side, all hex; side is cfg_bus, irq or stall cycles
# kind 0 txn, 1 txn+cfg_bus, 2 txn+irq, 3 issue only, 4 expect response, 5 txn after stall
1 1 200000 0 0 009
1 1 200008 2a 0 2a9
1 0 200000 0 0 2a9
1 0 200008 0 2a 2a9
0 0 200010 0 9 0
1 1 200018 ffff 0 2a9
0 0 200018 0 0 0
1 1 200000 1 0 6a9
2 1 100000 1 0 2
2 1 10b000 1 0 3
2 1 104000 0 0 7
2 1 104000 ffffffffffffffff 0 3
2 0 100000 0 1 3
2 0 104000 0 ffffffffffffffff 3
2 0 10b000 0 1 3
2 1 100000 0 0 1
2 1 10b000 0 0 0
0 0 80001000 0 80004a5a 0
0 1 80002000 1234 0 0
0 0 1234567890 0 12345622ca 0
0 0 100 0 5b5a 0
0 1 40 77 0 0
0 0 500040 0 0 0
0 1 5fff08 abcd 0 0
0 0 f00000 0 0 0
3 0 80003000 0 0 0
3 0 200008 0 0 0
4 0 80003000 0 80006a5a 0
4 0 200008 0 2a 0
3 0 80004000 0 0 0
3 0 104000 0 0 0
4 0 80004000 0 80001a5a 0
4 0 104000 0 ffffffffffffffff 0
5 0 200010 0 9 5
5 0 80005000 0 80000a5a 4
5 0 500000 0 0 3

// ==== dv/tile_mem_tb.sv ====
// Testbench for the tile memory fabric driven by the case file in dv/.
// Models the outside memory port and checks responses, cfg bus and irq levels.
`timescale 1ns/1ps

module tile_mem_tb
  import tile_mem_pkg::*;
  ();

  localparam paddr_t dram_base_c = 40'h00_8000_0000;
  localparam did_t   host_did_c  = 4'h9;

  typedef struct packed
  {
    logic [3:0]  kind;
    mem_opcode_e op;
    paddr_t      addr;
    dword_t      data;
    dword_t      exp_data;
    logic [31:0] side;
  } case_t;

  logic     clk_i;
  logic     reset_i;
  mem_msg_t cmd_i;
  logic     cmd_v_i;
  logic     cmd_ready_and_o;
  mem_msg_t resp_o;
  logic     resp_v_o;
  logic     resp_yumi_i;
  mem_msg_t mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_ready_and_i;
  mem_msg_t mem_resp_i;
  logic     mem_resp_v_i;
  logic     mem_resp_yumi_o;
  did_t     host_did_i;
  cfg_bus_t cfg_bus_o;
  irq_t     irq_o;

  case_t       cases[$];
  case_t       cur;
  mem_msg_t    mem_resp_q[$];
  mem_msg_t    model_cmd;
  logic        model_take;
  logic        model_pop;
  logic [31:0] lfsr_state = 32'ha97;
  int          mismatch_count = 0;
  int          other_count = 0;
  int          cycle_count = 0;
  int          timeout_limit = 100;
  int          fd;
  int          n;
  string       line;
  int          kind_in;
  int          op_in;
  paddr_t      addr_in;
  dword_t      data_in;
  dword_t      exp_in;
  logic [31:0] side_in;

  tile_mem_top
   #(.dram_base_addr_p(dram_base_c))
   dut_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_and_o(cmd_ready_and_o)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.host_did_i(host_did_i)
     ,.cfg_bus_o(cfg_bus_o)
     ,.irq_o(irq_o)
     );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic routes_to_mem(input paddr_t a);
    routes_to_mem = (a >= dram_base_c) || (a[23:20] == 4'h0);
  endfunction

  // Memory side answers in order one cycle after accepting
  function automatic mem_msg_t model_resp(input mem_msg_t cmd);
    mem_msg_t r;
    r.opcode = cmd.opcode;
    r.addr   = cmd.addr;
    r.data   = (cmd.opcode == e_mem_wr) ? '0 : dword_t'(cmd.addr ^ 40'h5a5a);
    return r;
  endfunction

  always
  begin
    @(negedge clk_i);
    model_take = mem_cmd_v_o && mem_cmd_ready_and_i;
    model_pop  = mem_resp_v_i && mem_resp_yumi_o;
    model_cmd  = mem_cmd_o;
    // Top priority passes the port yumi straight to the memory side
    if (reset_i === 1'b0)
      compare_strobe("mem_resp_yumi_o", mem_resp_yumi_o, mem_resp_v_i && resp_yumi_i);
    @(posedge clk_i);
    #1;
    if (model_pop)
      void'(mem_resp_q.pop_front());
    if (model_take)
      mem_resp_q.push_back(model_resp(model_cmd));
    mem_resp_v_i = (mem_resp_q.size() != 0);
    mem_resp_i   = (mem_resp_q.size() != 0) ? mem_resp_q[0] : '0;
  end

  task automatic check_resp(input string name, input mem_msg_t got, input mem_msg_t exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_irq(input irq_t got, input irq_t exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch irq_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_cfg(input cfg_bus_t got, input cfg_bus_t exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch cfg_bus_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic compare_strobe(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic insert_gap();
    logic [1:0] gap;
    gap = '0;
    repeat (2)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = {gap[0], lfsr_state[0]};
    end
    repeat (gap)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Holds the memory port off for stall cycles, then waits for the handover
  task automatic send_cmd(input mem_msg_t msg, input int stall);
    logic accepted;
    accepted = 1'b0;
    cmd_i = msg;
    cmd_v_i = 1'b1;
    mem_cmd_ready_and_i = (stall == 0);
    repeat (stall)
    begin
      @(negedge clk_i);
      if (cmd_ready_and_o !== 1'b0 || mem_cmd_v_o !== 1'b0 || dut_i.cfg_cmd_v !== 1'b0
          || dut_i.clint_cmd_v !== 1'b0 || dut_i.loopback_cmd_v !== 1'b0)
      begin
        other_count++;
        $display("command leaked to a target during a memory-port stall at %h", msg.addr);
      end
      @(posedge clk_i);
      #1;
    end
    mem_cmd_ready_and_i = 1'b1;
    while (!accepted)
    begin
      @(negedge clk_i);
      accepted = cmd_ready_and_o;
      if (accepted && mem_cmd_v_o !== routes_to_mem(msg.addr))
      begin
        other_count++;
        $display("memory port valid does not follow the address decode for %h", msg.addr);
      end
      if (accepted && routes_to_mem(msg.addr))
        check_resp("mem_cmd_o", mem_cmd_o, msg);
      @(posedge clk_i);
      #1;
    end
    cmd_v_i = 1'b0;
  endtask

  // Yumi rises once a response is held and drops after one cycle
  task automatic recv_resp(input mem_msg_t exp);
    logic seen;
    seen = 1'b0;
    while (!seen)
    begin
      @(negedge clk_i);
      seen = resp_v_o;
    end
    @(posedge clk_i);
    #1;
    resp_yumi_i = 1'b1;
    @(negedge clk_i);
    check_resp("resp_o", resp_o, exp);
    @(posedge clk_i);
    #1;
    resp_yumi_i = 1'b0;
  endtask

  initial
  begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    cmd_i = '0;
    cmd_v_i = 1'b0;
    resp_yumi_i = 1'b0;
    mem_cmd_ready_and_i = 1'b1;
    mem_resp_i = '0;
    mem_resp_v_i = 1'b0;
    host_did_i = host_did_c;

    fd = $fopen("dv/tile_mem_cases.txt", "r");
    if (fd == 0)
    begin
      other_count++;
      $display("cannot open the case file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line.getc(0) == "#")
          continue;
        n = $sscanf(line, "%h %h %h %h %h %h",
                    kind_in, op_in, addr_in, data_in, exp_in, side_in);
        if (n == 6)
        begin
          cur = '{kind: kind_in[3:0], op: mem_opcode_e'(op_in[0]), addr: addr_in,
                  data: data_in, exp_data: exp_in, side: side_in};
          cases.push_back(cur);
        end
        else if (n > 0)
        begin
          other_count++;
          $display("malformed case line: %s", line);
        end
      end
      $fclose(fd);
    end
    if (cases.size() == 0)
    begin
      other_count++;
      $display("no cases were read");
    end
    timeout_limit = 40 * cases.size() + 100;

    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    check_cfg(cfg_bus_o, '{freeze: 1'b1, core_id: '0, host_did: host_did_c});
    check_irq(irq_o, '0);
    if (resp_v_o !== 1'b0)
    begin
      other_count++;
      $display("response valid is high right after reset");
    end

    foreach (cases[i])
    begin
      cur = cases[i];
      insert_gap();
      case (cur.kind)
        4'd0, 4'd1, 4'd2, 4'd5:
        begin
          send_cmd('{opcode: cur.op, addr: cur.addr, data: cur.data},
                   (cur.kind == 4'd5) ? int'(cur.side) : 0);
          recv_resp('{opcode: cur.op, addr: cur.addr, data: cur.exp_data});
          if (cur.kind == 4'd1)
            check_cfg(cfg_bus_o, cfg_bus_t'(cur.side[10:0]));
          if (cur.kind == 4'd2)
            check_irq(irq_o, irq_t'(cur.side[2:0]));
        end
        4'd3:
          send_cmd('{opcode: cur.op, addr: cur.addr, data: cur.data}, 0);
        4'd4:
          recv_resp('{opcode: cur.op, addr: cur.addr, data: cur.exp_data});
        default:
        begin
          other_count++;
          $display("unknown case kind %h", cur.kind);
        end
      endcase
    end

    repeat (4) @(posedge clk_i);
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== verilog/cfg_regs.sv ====
// Tile configuration registers for freeze, core id and the host domain id.
// Each accepted command leaves one response in a single-entry buffer.
`timescale 1ns/1ps

module cfg_regs
  import tile_mem_pkg::*;
  (input logic          clk_i
   , input logic        reset_i

   , input mem_msg_t    cmd_i
   , input logic        cmd_v_i
   , output logic       cmd_ready_o

   , output mem_msg_t   resp_o
   , output logic       resp_v_o
   , input logic        resp_yumi_i

   , input did_t        host_did_i
   , output cfg_bus_t   cfg_bus_o
   );

  local_addr_t cmd_addr;
  dev_offset_t offset;
  logic        is_write;
  logic        cmd_accept;
  dword_t      rdata;
  logic        freeze_r;
  core_id_t    core_id_r;
  mem_msg_t    resp_r;
  logic        resp_v_r;

  assign cmd_addr   = cmd_i.addr;
  assign offset     = cmd_addr.offset;
  assign is_write   = (cmd_i.opcode == e_mem_wr);
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_accept = cmd_v_i & cmd_ready_o;

  // Writes and unknown offsets answer with zero
  always_comb
  begin
    rdata = '0;
    if (!is_write)
    begin
      case (offset)
        cfg_freeze_offset_c:   rdata = dword_t'(freeze_r);
        cfg_core_id_offset_c:  rdata = dword_t'(core_id_r);
        cfg_host_did_offset_c: rdata = dword_t'(host_did_i);
        default:               rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_r  <= 1'b1;
      core_id_r <= '0;
    end
    else if (cmd_accept & is_write)
    begin
      if (offset == cfg_freeze_offset_c)
        freeze_r <= cmd_i.data[0];
      else if (offset == cfg_core_id_offset_c)
        core_id_r <= cmd_i.data[$bits(core_id_t)-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
      resp_r <= '{opcode: cmd_i.opcode, addr: cmd_i.addr, data: rdata};
  end

  assign resp_o    = resp_r;
  assign resp_v_o  = resp_v_r;
  assign cfg_bus_o = '{freeze: freeze_r, core_id: core_id_r, host_did: host_did_i};

endmodule

// ==== verilog/clint_slice.sv ====
// Core-local interruptor with machine timer, timer compare, software and external bits.
// Register access uses the same single-entry response buffer as the other devices.
`timescale 1ns/1ps

module clint_slice
  import tile_mem_pkg::*;
  (input logic          clk_i
   , input logic        reset_i

   , input mem_msg_t    cmd_i
   , input logic        cmd_v_i
   , output logic       cmd_ready_o

   , output mem_msg_t   resp_o
   , output logic       resp_v_o
   , input logic        resp_yumi_i

   , output irq_t       irq_o
   );

  local_addr_t cmd_addr;
  dev_offset_t offset;
  logic        is_write;
  logic        cmd_accept;
  dword_t      rdata;
  dword_t      mtime_r;
  dword_t      mtimecmp_r;
  logic        msip_r;
  logic        plic_r;
  mem_msg_t    resp_r;
  logic        resp_v_r;

  assign cmd_addr    = cmd_i.addr;
  assign offset      = cmd_addr.offset;
  assign is_write    = (cmd_i.opcode == e_mem_wr);
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_accept  = cmd_v_i & cmd_ready_o;

  always_comb
  begin
    rdata = '0;
    if (!is_write)
    begin
      case (offset)
        clint_msip_offset_c:     rdata = dword_t'(msip_r);
        clint_mtimecmp_offset_c: rdata = mtimecmp_r;
        clint_plic_offset_c:     rdata = dword_t'(plic_r);
        clint_mtime_offset_c:    rdata = mtime_r;
        default:                 rdata = '0;
      endcase
    end
  end

  // mtime free-runs and a write to it takes over for that cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      plic_r     <= 1'b0;
    end
    else
    begin
      mtime_r <= mtime_r + 1'b1;
      if (cmd_accept & is_write)
      begin
        case (offset)
          clint_msip_offset_c:     msip_r <= cmd_i.data[0];
          clint_mtimecmp_offset_c: mtimecmp_r <= cmd_i.data;
          clint_plic_offset_c:     plic_r <= cmd_i.data[0];
          clint_mtime_offset_c:    mtime_r <= cmd_i.data;
          default:                 ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
      resp_r <= '{opcode: cmd_i.opcode, addr: cmd_i.addr, data: rdata};
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  // Timer level holds while mtime has reached the compare value
  assign irq_o = '{timer: (mtime_r >= mtimecmp_r), software: msip_r, external: plic_r};

endmodule

// ==== verilog/loopback_dev.sv ====
// Catch-all device for unmapped local addresses.
// Echoes opcode and address back with zero data.
`timescale 1ns/1ps

module loopback_dev
  import tile_mem_pkg::*;
  (input logic          clk_i
   , input logic        reset_i

   , input mem_msg_t    cmd_i
   , input logic        cmd_v_i
   , output logic       cmd_ready_o

   , output mem_msg_t   resp_o
   , output logic       resp_v_o
   , input logic        resp_yumi_i
   );

  logic     cmd_accept;
  mem_msg_t resp_r;
  logic     resp_v_r;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_accept  = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
      resp_r <= '{opcode: cmd_i.opcode, addr: cmd_i.addr, data: '0};
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

endmodule

// ==== verilog/mem_cmd_dispatch.sv ====
// Address decode of the tile command stream and fan-out to the four targets.
// Exactly one target valid rises, and only when every target is ready.
`timescale 1ns/1ps

module mem_cmd_dispatch
  import tile_mem_pkg::*;
  #(parameter paddr_t dram_base_addr_p = 40'h00_8000_0000)
  (input mem_msg_t      cmd_i
   , input logic        cmd_v_i
   , output logic       cmd_ready_and_o

   , input logic        mem_ready_i
   , input logic        cfg_ready_i
   , input logic        clint_ready_i
   , input logic        loopback_ready_i

   , output logic       mem_v_o
   , output logic       cfg_v_o
   , output logic       clint_v_o
   , output logic       loopback_v_o
   );

  local_addr_t local_addr;
  dev_id_t     dev_id;
  logic        is_local;
  logic        is_mem;
  logic        is_cfg;
  logic        is_clint;
  logic        is_loopback;
  logic        cmd_fire;

  assign local_addr = cmd_i.addr;
  assign dev_id     = local_addr.dev;
  assign is_local   = (cmd_i.addr < dram_base_addr_p);

  // Device 0 in the local window is routed out to the cache side
  assign is_mem      = ~is_local | (dev_id == cache_dev_c);
  assign is_cfg      = is_local & (dev_id == cfg_dev_c);
  assign is_clint    = is_local & (dev_id == clint_dev_c);
  assign is_loopback = is_local & ~is_mem & ~is_cfg & ~is_clint;

  assign cmd_ready_and_o = mem_ready_i & cfg_ready_i & clint_ready_i & loopback_ready_i;

  // Gate with the combined ready so a target never consumes
  // a command the source still holds
  assign cmd_fire = cmd_v_i & cmd_ready_and_o;

  assign mem_v_o      = is_mem & cmd_fire;
  assign cfg_v_o      = is_cfg & cmd_fire;
  assign clint_v_o    = is_clint & cmd_fire;
  assign loopback_v_o = is_loopback & cmd_fire;

endmodule

// ==== verilog/mem_resp_arbiter.sv ====
// Fixed-priority merge of the four response sources onto one response port.
// Memory port wins, then cfg, clint and loopback.
`timescale 1ns/1ps

module mem_resp_arbiter
  import tile_mem_pkg::*;
  (input mem_msg_t      mem_resp_i
   , input logic        mem_resp_v_i
   , output logic       mem_resp_yumi_o
   , input mem_msg_t    cfg_resp_i
   , input logic        cfg_resp_v_i
   , output logic       cfg_resp_yumi_o
   , input mem_msg_t    clint_resp_i
   , input logic        clint_resp_v_i
   , output logic       clint_resp_yumi_o
   , input mem_msg_t    loopback_resp_i
   , input logic        loopback_resp_v_i
   , output logic       loopback_resp_yumi_o

   , output mem_msg_t   resp_o
   , output logic       resp_v_o
   , input logic        resp_yumi_i
   );

  logic [3:0] req;
  logic [3:0] grant;

  // Bit 0 is the highest priority
  assign req   = {loopback_resp_v_i, clint_resp_v_i, cfg_resp_v_i, mem_resp_v_i};
  assign grant = req & ~(req - 4'd1);

  always_comb
  begin
    case (grant)
      4'b0001: resp_o = mem_resp_i;
      4'b0010: resp_o = cfg_resp_i;
      4'b0100: resp_o = clint_resp_i;
      4'b1000: resp_o = loopback_resp_i;
      default: resp_o = '0;
    endcase
  end

  assign resp_v_o = |req;

  assign mem_resp_yumi_o      = resp_yumi_i & grant[0];
  assign cfg_resp_yumi_o      = resp_yumi_i & grant[1];
  assign clint_resp_yumi_o    = resp_yumi_i & grant[2];
  assign loopback_resp_yumi_o = resp_yumi_i & grant[3];

endmodule

// ==== verilog/tile_mem_pkg.sv ====
// Types, address map and register offsets of the tile memory fabric.
// Every RTL module takes what it needs by a wildcard import.
package tile_mem_pkg;

  typedef logic [39:0] paddr_t;
  typedef logic [63:0] dword_t;
  typedef logic [3:0]  dev_id_t;
  typedef logic [19:0] dev_offset_t;
  typedef logic [5:0]  core_id_t;
  typedef logic [3:0]  did_t;

  typedef enum logic [0:0]
  {
    e_mem_rd   = 1'b0
    , e_mem_wr = 1'b1
  } mem_opcode_e;

  // Single-beat message for commands and responses alike
  typedef struct packed
  {
    mem_opcode_e opcode;
    paddr_t      addr;
    dword_t      data;
  } mem_msg_t;

  // View of a local address below the DRAM base
  typedef struct packed
  {
    logic [15:0] upper;
    dev_id_t     dev;
    dev_offset_t offset;
  } local_addr_t;

  typedef struct packed
  {
    logic     freeze;
    core_id_t core_id;
    did_t     host_did;
  } cfg_bus_t;

  typedef struct packed
  {
    logic timer;
    logic software;
    logic external;
  } irq_t;

  localparam dev_id_t cache_dev_c = 4'd0;
  localparam dev_id_t clint_dev_c = 4'd1;
  localparam dev_id_t cfg_dev_c   = 4'd2;

  localparam dev_offset_t cfg_freeze_offset_c   = 20'h0_0000;
  localparam dev_offset_t cfg_core_id_offset_c  = 20'h0_0008;
  localparam dev_offset_t cfg_host_did_offset_c = 20'h0_0010;

  // CLINT layout follows the usual RISC-V offsets
  localparam dev_offset_t clint_msip_offset_c     = 20'h0_0000;
  localparam dev_offset_t clint_mtimecmp_offset_c = 20'h0_4000;
  localparam dev_offset_t clint_plic_offset_c     = 20'h0_b000;
  localparam dev_offset_t clint_mtime_offset_c    = 20'h0_bff8;

endpackage

// ==== verilog/tile_mem_top.sv ====
// Memory-side command fabric of one tile with dispatch, local devices and response merge.
// The memory port leaves the tile for the L2 and DRAM path.
`timescale 1ns/1ps

module tile_mem_top
  import tile_mem_pkg::*;
  #(parameter paddr_t dram_base_addr_p = 40'h00_8000_0000)
  (input logic          clk_i
   , input logic        reset_i

   , input mem_msg_t    cmd_i
   , input logic        cmd_v_i
   , output logic       cmd_ready_and_o

   , output mem_msg_t   resp_o
   , output logic       resp_v_o
   , input logic        resp_yumi_i

   , output mem_msg_t   mem_cmd_o
   , output logic       mem_cmd_v_o
   , input logic        mem_cmd_ready_and_i
   , input mem_msg_t    mem_resp_i
   , input logic        mem_resp_v_i
   , output logic       mem_resp_yumi_o

   , input did_t        host_did_i
   , output cfg_bus_t   cfg_bus_o
   , output irq_t       irq_o
   );

  logic     reset_r;
  logic     cfg_cmd_v, cfg_cmd_ready;
  logic     clint_cmd_v, clint_cmd_ready;
  logic     loopback_cmd_v, loopback_cmd_ready;
  mem_msg_t cfg_resp, clint_resp, loopback_resp;
  logic     cfg_resp_v, clint_resp_v, loopback_resp_v;
  logic     cfg_resp_yumi, clint_resp_yumi, loopback_resp_yumi;

  // One register stage on reset before it fans out to the devices
  always_ff @(posedge clk_i)
    reset_r <= reset_i;

  // Command payload goes to every target and only the valid is steered
  assign mem_cmd_o = cmd_i;

  mem_cmd_dispatch
   #(.dram_base_addr_p(dram_base_addr_p))
   dispatch
    (.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_and_o(cmd_ready_and_o)
     ,.mem_ready_i(mem_cmd_ready_and_i)
     ,.cfg_ready_i(cfg_cmd_ready)
     ,.clint_ready_i(clint_cmd_ready)
     ,.loopback_ready_i(loopback_cmd_ready)
     ,.mem_v_o(mem_cmd_v_o)
     ,.cfg_v_o(cfg_cmd_v)
     ,.clint_v_o(clint_cmd_v)
     ,.loopback_v_o(loopback_cmd_v)
     );

  cfg_regs
   cfg
    (.clk_i(clk_i)
     ,.reset_i(reset_r)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cfg_cmd_v)
     ,.cmd_ready_o(cfg_cmd_ready)
     ,.resp_o(cfg_resp)
     ,.resp_v_o(cfg_resp_v)
     ,.resp_yumi_i(cfg_resp_yumi)
     ,.host_did_i(host_did_i)
     ,.cfg_bus_o(cfg_bus_o)
     );

  clint_slice
   clint
    (.clk_i(clk_i)
     ,.reset_i(reset_r)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(clint_cmd_v)
     ,.cmd_ready_o(clint_cmd_ready)
     ,.resp_o(clint_resp)
     ,.resp_v_o(clint_resp_v)
     ,.resp_yumi_i(clint_resp_yumi)
     ,.irq_o(irq_o)
     );

  loopback_dev
   loopback
    (.clk_i(clk_i)
     ,.reset_i(reset_r)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(loopback_cmd_v)
     ,.cmd_ready_o(loopback_cmd_ready)
     ,.resp_o(loopback_resp)
     ,.resp_v_o(loopback_resp_v)
     ,.resp_yumi_i(loopback_resp_yumi)
     );

  mem_resp_arbiter
   resp_arb
    (.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.cfg_resp_i(cfg_resp)
     ,.cfg_resp_v_i(cfg_resp_v)
     ,.cfg_resp_yumi_o(cfg_resp_yumi)
     ,.clint_resp_i(clint_resp)
     ,.clint_resp_v_i(clint_resp_v)
     ,.clint_resp_yumi_o(clint_resp_yumi)
     ,.loopback_resp_i(loopback_resp)
     ,.loopback_resp_v_i(loopback_resp_v)
     ,.loopback_resp_yumi_o(loopback_resp_yumi)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_yumi_i(resp_yumi_i)
     );

endmodule

// ==== vlog.f ====
verilog/tile_mem_pkg.sv
verilog/mem_cmd_dispatch.sv
verilog/mem_resp_arbiter.sv
verilog/cfg_regs.sv
verilog/clint_slice.sv
verilog/loopback_dev.sv
verilog/tile_mem_top.sv
dv/tile_mem_tb.sv
